//--- hdl/lsq_core_pkg.sv
/*
 * Core-side definitions for the load/store queue
 * Operand width, physical register tags, ROB indices and the
 * operation encoding seen at dispatch
 */
package lsq_core_pkg;

	// Operand or memory value
	typedef logic [63:0] data_t;

	// Physical register tag, 64 registers
	typedef logic [5:0] prf_tag_t;

	// ROB index, 32 entries
	typedef logic [4:0] rob_idx_t;

	// Memory operation kind at dispatch
	typedef enum logic [1:0] {
		op_none,
		op_load,
		op_store
	} lsq_op_e;

	// Stores write no register
	localparam prf_tag_t none_tag = '0;

endpackage

//--- hdl/lsq_bus_pkg.sv
/*
 * Data-cache port definitions
 * Byte addresses, transaction tags and bus commands
 */
package lsq_bus_pkg;

	typedef logic [63:0] addr_t;   // Byte address

	// Zero on mem_response means the request was refused
	typedef logic [3:0] mem_tag_t;

	typedef enum logic [1:0] {
		bus_none,
		bus_load,
		bus_store
	} bus_command_e;

endpackage

//--- hdl/lsq_dispatch.sv
`timescale 1ns/1ps
/*
 * LSQ dispatch stage
 * Fills waiting operands from the CDB, steers each instruction to the
 * load or store queue and registers the combined full flag
 */
module lsq_dispatch import lsq_core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     inst_valid,
	input  lsq_op_e  inst_op,
	input  data_t    inst_opb,
	input  logic     inst_opb_valid,
	input  data_t    inst_rega,
	input  logic     inst_rega_valid,
	input  logic     cdb_in_valid,
	input  prf_tag_t cdb_in_tag,
	input  data_t    cdb_in_data,
	input  logic     mispredict,
	input  logic     lq_full,
	input  logic     sq_full,
	output logic     lq_alloc,
	output logic     sq_alloc,
	output data_t    opb,
	output logic     opb_valid,
	output data_t    rega,
	output logic     rega_valid,
	output logic     lsq_full
);
	logic accept;

	// Catch a broadcast that lands in the dispatch cycle
	always_comb begin
		opb        = inst_opb;
		opb_valid  = inst_opb_valid;
		rega       = inst_rega;
		rega_valid = inst_rega_valid;
		if (!inst_opb_valid && cdb_in_valid && cdb_in_tag == prf_tag_t'(inst_opb)) begin
			opb       = cdb_in_data;
			opb_valid = 1'b1;
		end
		if (!inst_rega_valid && cdb_in_valid && cdb_in_tag == prf_tag_t'(inst_rega)) begin
			rega       = cdb_in_data;
			rega_valid = 1'b1;
		end
	end

	assign accept   = inst_valid && !lsq_full && !mispredict;
	assign lq_alloc = accept && inst_op == op_load && !lq_full;    // Own flag covers the lag
	assign sq_alloc = accept && inst_op == op_store && !sq_full;

	always_ff @(posedge clock) begin
		if (reset) begin
			lsq_full <= 1'b0;
		end else begin
			lsq_full <= lq_full || sq_full;
		end
	end

endmodule

//--- hdl/load_queue.sv
`timescale 1ns/1ps
/*
 * Load queue
 * Holds dispatched loads, wakes offsets from the CDB, issues the lowest
 * ready load that is older than every store, maps cache tags to slots
 * and presents returned data as results
 */
module load_queue import lsq_core_pkg::*, lsq_bus_pkg::*; #(
	parameter int lq_size = 8
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     lq_alloc,
	input  data_t    inst_opa,
	input  data_t    opb,
	input  logic     opb_valid,
	input  rob_idx_t inst_rob_idx,
	input  prf_tag_t inst_dest_tag,
	input  logic     cdb_in_valid,
	input  prf_tag_t cdb_in_tag,
	input  data_t    cdb_in_data,
	input  rob_idx_t rob_head,
	input  logic     sq_oldest_valid,
	input  rob_idx_t sq_oldest_rob_idx,
	input  logic     mispredict,
	input  logic     lq_grant,
	input  mem_tag_t mem_response,
	input  mem_tag_t mem_tag,
	input  data_t    mem_data_in,
	output logic     lq_req,
	output addr_t    lq_req_addr,
	output logic     lq_result_valid,
	output prf_tag_t lq_result_tag,
	output rob_idx_t lq_result_rob_idx,
	output data_t    lq_result_data,
	input  logic     lq_result_taken,
	output logic     lq_full
);
	localparam int lq_idx_w  = $clog2(lq_size);
	localparam int tag_count = 2 ** $bits(mem_tag_t);

	typedef logic [lq_idx_w-1:0] lq_slot_t;

	logic [lq_size-1:0] busy;
	logic [lq_size-1:0] issued;      // Accepted by the cache
	logic [lq_size-1:0] done;        // Data back, waiting for the CDB
	logic [lq_size-1:0] off_valid;
	data_t              base [lq_size];
	data_t              offset [lq_size];
	rob_idx_t           rob_idx [lq_size];
	prf_tag_t           dest_tag [lq_size];
	data_t              load_data [lq_size];

	logic [tag_count-1:0] tag_valid;
	lq_slot_t             tag_slot [tag_count];

	lq_slot_t alloc_slot;
	lq_slot_t pick_slot;
	lq_slot_t issue_slot;
	lq_slot_t result_slot;
	lq_slot_t ret_slot;
	lq_slot_t pend_slot;
	logic     pick_found;
	logic     pend_valid;      // Request seen but not yet granted
	logic     ret_hit;

	////////////////////////////////////////
	// Slot selection
	////////////////////////////////////////

	// Descending scans so the lowest slot wins
	always_comb begin
		alloc_slot = '0;
		for (int i = lq_size - 1; i >= 0; i--) begin
			if (!busy[i]) alloc_slot = lq_slot_t'(i);
		end
	end

	always_comb begin
		rob_idx_t load_age;
		rob_idx_t store_age;
		pick_found = 1'b0;
		pick_slot  = '0;
		store_age  = sq_oldest_rob_idx - rob_head;
		for (int i = lq_size - 1; i >= 0; i--) begin
			load_age = rob_idx[i] - rob_head;    // Distance from the ROB head
			if (busy[i] && off_valid[i] && !issued[i] &&
					(!sq_oldest_valid || load_age < store_age)) begin
				pick_found = 1'b1;
				pick_slot  = lq_slot_t'(i);
			end
		end
	end

	always_comb begin
		lq_result_valid = 1'b0;
		result_slot     = '0;
		for (int i = lq_size - 1; i >= 0; i--) begin
			if (done[i]) begin
				lq_result_valid = 1'b1;
				result_slot     = lq_slot_t'(i);
			end
		end
	end

	// A refused load keeps its slot so the grant names the right entry
	assign issue_slot  = pend_valid ? pend_slot : pick_slot;
	assign lq_req      = pend_valid || pick_found;
	assign lq_req_addr = base[issue_slot] + offset[issue_slot];

	assign lq_result_tag     = dest_tag[result_slot];
	assign lq_result_rob_idx = rob_idx[result_slot];
	assign lq_result_data    = load_data[result_slot];
	assign lq_full           = &busy;

	assign ret_hit  = tag_valid[mem_tag];    // Tag zero is never mapped
	assign ret_slot = tag_slot[mem_tag];

	////////////////////////////////////////
	// Entry control
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin    // Squash also orphans late returns
			busy       <= '0;
			issued     <= '0;
			done       <= '0;
			tag_valid  <= '0;
			pend_valid <= 1'b0;
		end else begin
			if (ret_hit) begin
				done[ret_slot]     <= 1'b1;
				tag_valid[mem_tag] <= 1'b0;
			end
			if (lq_grant) begin
				issued[issue_slot]      <= 1'b1;
				tag_valid[mem_response] <= 1'b1;
			end
			if (lq_result_valid && lq_result_taken) begin
				busy[result_slot]   <= 1'b0;
				issued[result_slot] <= 1'b0;
				done[result_slot]   <= 1'b0;
			end
			if (lq_alloc) begin
				busy[alloc_slot]   <= 1'b1;
				issued[alloc_slot] <= 1'b0;
				done[alloc_slot]   <= 1'b0;
			end
			pend_valid <= lq_req && !lq_grant;
		end
	end

	always_ff @(posedge clock) begin
		pend_slot <= issue_slot;
		if (lq_grant) tag_slot[mem_response] <= issue_slot;
		if (ret_hit) load_data[ret_slot] <= mem_data_in;
		for (int i = 0; i < lq_size; i++) begin
			if (busy[i] && !off_valid[i] && cdb_in_valid &&
					cdb_in_tag == prf_tag_t'(offset[i])) begin
				offset[i]    <= cdb_in_data;
				off_valid[i] <= 1'b1;
			end
		end
		if (lq_alloc) begin    // Dispatch already bypassed this cycle's CDB
			base[alloc_slot]      <= inst_opa;
			offset[alloc_slot]    <= opb;
			off_valid[alloc_slot] <= opb_valid;
			rob_idx[alloc_slot]   <= inst_rob_idx;
			dest_tag[alloc_slot]  <= inst_dest_tag;
		end
	end

	// Every cache return names a load that is issued and still waiting
	assert property (@(posedge clock) disable iff (reset)
		ret_hit |-> busy[ret_slot] && issued[ret_slot] && !done[ret_slot]);

endmodule

//--- hdl/store_queue.sv
`timescale 1ns/1ps
/*
 * Store queue
 * Circular buffer of stores in program order; the head store writes
 * the cache once it is ready and at the head of the ROB
 */
module store_queue import lsq_core_pkg::*, lsq_bus_pkg::*; #(
	parameter int sq_size = 8
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     sq_alloc,
	input  data_t    inst_opa,
	input  data_t    opb,
	input  logic     opb_valid,
	input  data_t    rega,
	input  logic     rega_valid,
	input  rob_idx_t inst_rob_idx,
	input  logic     cdb_in_valid,
	input  prf_tag_t cdb_in_tag,
	input  data_t    cdb_in_data,
	input  rob_idx_t rob_head,
	input  logic     mispredict,
	input  logic     sq_grant,
	output logic     sq_req,
	output addr_t    sq_req_addr,
	output data_t    sq_req_data,
	output logic     sq_oldest_valid,
	output rob_idx_t sq_oldest_rob_idx,
	output logic     sq_done,
	output rob_idx_t sq_done_rob_idx,
	output logic     sq_full
);
	localparam int sq_idx_w = $clog2(sq_size);

	typedef logic [sq_idx_w:0]   sq_ptr_t;    // Extra wrap bit
	typedef logic [sq_idx_w-1:0] sq_slot_t;

	sq_ptr_t  head;
	sq_ptr_t  tail;
	sq_slot_t head_slot;
	sq_slot_t tail_slot;
	logic     sq_empty;

	data_t              base [sq_size];
	data_t              offset [sq_size];
	data_t              store_data [sq_size];
	rob_idx_t           rob_idx [sq_size];
	logic [sq_size-1:0] off_valid;
	logic [sq_size-1:0] data_valid;

	assign head_slot = head[sq_idx_w-1:0];
	assign tail_slot = tail[sq_idx_w-1:0];
	assign sq_empty  = head == tail;
	assign sq_full   = head == {~tail[sq_idx_w], tail_slot};

	// Stores stay in order, so the head is the oldest
	assign sq_oldest_valid   = !sq_empty;
	assign sq_oldest_rob_idx = rob_idx[head_slot];

	////////////////////////////////////////
	// Commit-time issue
	////////////////////////////////////////

	assign sq_req = !sq_empty && off_valid[head_slot] && data_valid[head_slot] &&
		rob_idx[head_slot] == rob_head;
	assign sq_req_addr = base[head_slot] + offset[head_slot];
	assign sq_req_data = store_data[head_slot];

	assign sq_done         = sq_grant;    // Retires the head
	assign sq_done_rob_idx = rob_idx[head_slot];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (sq_grant) head <= head + 1'b1;
			// A committing head store is past the branch and survives
			if (mispredict) begin
				tail <= head + sq_ptr_t'(sq_req);
			end else if (sq_alloc) begin
				tail <= tail + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Entries and wakeup
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < sq_size; i++) begin
			if (!off_valid[i] && cdb_in_valid && cdb_in_tag == prf_tag_t'(offset[i])) begin
				offset[i]    <= cdb_in_data;
				off_valid[i] <= 1'b1;
			end
			if (!data_valid[i] && cdb_in_valid &&
					cdb_in_tag == prf_tag_t'(store_data[i])) begin
				store_data[i] <= cdb_in_data;
				data_valid[i] <= 1'b1;
			end
		end
		if (sq_alloc) begin
			base[tail_slot]       <= inst_opa;
			offset[tail_slot]     <= opb;
			off_valid[tail_slot]  <= opb_valid;
			store_data[tail_slot] <= rega;
			data_valid[tail_slot] <= rega_valid;
			rob_idx[tail_slot]    <= inst_rob_idx;
		end
	end

	// Dispatch must hold stores back while the buffer is full
	assert property (@(posedge clock) disable iff (reset) sq_alloc |-> !sq_full);

endmodule

//--- hdl/dcache_arbiter.sv
`timescale 1ns/1ps
/*
 * Data-cache port arbiter
 * Stores win over loads; a refused request is held and replayed
 * every cycle until the cache accepts it
 */
module dcache_arbiter import lsq_core_pkg::*, lsq_bus_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         lq_req,
	input  addr_t        lq_req_addr,
	input  logic         sq_req,
	input  addr_t        sq_req_addr,
	input  data_t        sq_req_data,
	input  logic         mispredict,
	input  mem_tag_t     mem_response,
	output logic         lq_grant,
	output logic         sq_grant,
	output bus_command_e mem_command,
	output addr_t        mem_address,
	output data_t        mem_data_out
);
	logic  held_valid;
	logic  held_is_store;
	addr_t held_addr;
	data_t held_data;
	logic  accepted;

	always_comb begin
		mem_command  = bus_none;
		mem_address  = '0;
		mem_data_out = '0;
		if (held_valid) begin    // Replay blocks new requests
			if (held_is_store) begin
				mem_command  = bus_store;
				mem_address  = held_addr;
				mem_data_out = held_data;
			end else if (!mispredict) begin
				mem_command = bus_load;
				mem_address = held_addr;
			end
		end else if (sq_req) begin
			mem_command  = bus_store;
			mem_address  = sq_req_addr;
			mem_data_out = sq_req_data;
		end else if (lq_req && !mispredict) begin    // No loads for a squashed path
			mem_command = bus_load;
			mem_address = lq_req_addr;
		end
	end

	assign accepted = mem_response != '0;
	assign sq_grant = accepted && mem_command == bus_store;
	assign lq_grant = accepted && mem_command == bus_load;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (held_valid) begin
			if (accepted || (mispredict && !held_is_store)) held_valid <= 1'b0;
		end else if (mem_command != bus_none && !accepted) begin
			held_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!held_valid) begin
			held_is_store <= mem_command == bus_store;
			held_addr     <= mem_address;
			held_data     <= mem_data_out;
		end
	end

	// A refused command is driven again unchanged, unless a squash drops a load
	assert property (@(posedge clock) disable iff (reset)
		mem_command != bus_none && !accepted
		|=> (mem_command == $past(mem_command) && mem_address == $past(mem_address) &&
			mem_data_out == $past(mem_data_out)) ||
			(mispredict && $past(mem_command) == bus_load));

endmodule

//--- hdl/result_arbiter.sv
`timescale 1ns/1ps
/*
 * Outgoing CDB arbiter
 * Registers one result per cycle; store completions win, a load
 * result waits until the bus is free
 */
module result_arbiter import lsq_core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     sq_done,
	input  rob_idx_t sq_done_rob_idx,
	input  logic     lq_result_valid,
	input  prf_tag_t lq_result_tag,
	input  rob_idx_t lq_result_rob_idx,
	input  data_t    lq_result_data,
	output logic     lq_result_taken,
	output logic     cdb_valid,
	output prf_tag_t cdb_tag,
	output rob_idx_t cdb_rob_idx,
	output data_t    cdb_data
);
	assign lq_result_taken = lq_result_valid && !sq_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= sq_done || lq_result_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (sq_done) begin
			cdb_tag     <= none_tag;    // Stores write no register
			cdb_rob_idx <= sq_done_rob_idx;
			cdb_data    <= '0;
		end else begin
			cdb_tag     <= lq_result_tag;
			cdb_rob_idx <= lq_result_rob_idx;
			cdb_data    <= lq_result_data;
		end
	end

endmodule

//--- hdl/lsq_top.sv
`timescale 1ns/1ps
/*
 * Load/store queue top level
 * Dispatch, load and store queues, cache port and CDB arbiters
 */
module lsq_top import lsq_core_pkg::*, lsq_bus_pkg::*; #(
	parameter int lq_size = 8,    // Powers of two
	parameter int sq_size = 8
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         inst_valid,
	input  lsq_op_e      inst_op,
	input  data_t        inst_opa,
	input  data_t        inst_opb,
	input  logic         inst_opb_valid,
	input  data_t        inst_rega,
	input  logic         inst_rega_valid,
	input  rob_idx_t     inst_rob_idx,
	input  prf_tag_t     inst_dest_tag,
	input  logic         cdb_in_valid,
	input  prf_tag_t     cdb_in_tag,
	input  data_t        cdb_in_data,
	input  rob_idx_t     rob_head,
	input  logic         mispredict,
	input  mem_tag_t     mem_response,
	input  mem_tag_t     mem_tag,
	input  data_t        mem_data_in,
	output bus_command_e mem_command,
	output addr_t        mem_address,
	output data_t        mem_data_out,
	output logic         cdb_valid,
	output prf_tag_t     cdb_tag,
	output rob_idx_t     cdb_rob_idx,
	output data_t        cdb_data,
	output logic         lsq_full
);
	////////////////////////////////////////
	// Dispatch to queues
	////////////////////////////////////////
	logic  lq_alloc;
	logic  sq_alloc;
	data_t opb;
	logic  opb_valid;
	data_t rega;
	logic  rega_valid;
	logic  lq_full;
	logic  sq_full;

	////////////////////////////////////////
	// Queues to arbiters
	////////////////////////////////////////
	logic     lq_req;
	addr_t    lq_req_addr;
	logic     lq_grant;
	logic     sq_req;
	addr_t    sq_req_addr;
	data_t    sq_req_data;
	logic     sq_grant;
	logic     sq_oldest_valid;
	rob_idx_t sq_oldest_rob_idx;
	logic     sq_done;
	rob_idx_t sq_done_rob_idx;
	logic     lq_result_valid;
	prf_tag_t lq_result_tag;
	rob_idx_t lq_result_rob_idx;
	data_t    lq_result_data;
	logic     lq_result_taken;

	lsq_dispatch u_dispatch (.*);

	load_queue #(.lq_size(lq_size)) u_load_queue (.*);

	store_queue #(.sq_size(sq_size)) u_store_queue (.*);

	dcache_arbiter u_dcache_arbiter (.*);

	result_arbiter u_result_arbiter (.*);

endmodule

//--- test/lsq_clock_gen.sv
`timescale 1ns/1ps
/*
 * Testbench clock and reset
 * 10 ns clock, reset held for the first three rising edges
 */
module lsq_clock_gen (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- test/dcache_model.sv
`timescale 1ns/1ps
/*
 * Data-cache model
 * Sparse memory that answers in the same cycle with a rotating tag,
 * refuses on LFSR bits when enabled, and returns load data 3 cycles later
 */
module dcache_model import lsq_core_pkg::*, lsq_bus_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         refuse_enable,
	input  bus_command_e mem_command,
	input  addr_t        mem_address,
	input  data_t        mem_data_out,
	output mem_tag_t     mem_response,
	output mem_tag_t     mem_tag,
	output data_t        mem_data_in
);
	localparam logic [31:0] lfsr_seed = 32'hcd3b_3876;
	localparam data_t       fill_key  = 64'h5a5a_0000_0000_0000;

	data_t            mem [addr_t];            // Only written words are stored
	logic [31:0]      lfsr      = lfsr_seed;
	mem_tag_t         next_tag  = 4'd1;
	logic [2:0][3:0]  ret_tag   = '0;          // Three-stage return pipe
	logic [2:0][63:0] ret_data  = '0;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic data_t read_word(input addr_t a);
		if (mem.exists(a)) return mem[a];
		return a ^ fill_key;
	endfunction

	// Low LFSR bit is the refusal bit for this request
	assign mem_response = (mem_command != bus_none && !(refuse_enable && lfsr[0])) ?
		next_tag : '0;
	assign mem_tag      = ret_tag[2];
	assign mem_data_in  = ret_data[2];

	always @(posedge clock) begin
		if (reset) begin
			lfsr     <= lfsr_seed;
			next_tag <= 4'd1;
			ret_tag  <= '0;
		end else begin
			if (refuse_enable && mem_command != bus_none) lfsr <= lfsr_step(lfsr);    // One step per bit used
			ret_tag[2]  <= ret_tag[1];
			ret_tag[1]  <= ret_tag[0];
			ret_tag[0]  <= '0;
			ret_data[2] <= ret_data[1];
			ret_data[1] <= ret_data[0];
			if (mem_response != '0) begin
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
				if (mem_command == bus_store) begin
					mem[mem_address] = mem_data_out;
				end else begin
					ret_tag[0]  <= mem_response;
					ret_data[0] <= read_word(mem_address);
				end
			end
		end
	end

endmodule

//--- test/lsq_tb.sv
`timescale 1ns/1ps
/*
 * Load/store queue testbench
 * Directed tests for dispatch, CDB wakeup, store ordering,
 * cache refusals and mispredict squash
 */
module lsq_tb import lsq_core_pkg::*, lsq_bus_pkg::*; ();
	localparam int    timeout_cycles = 2000;    // Six tests, each well under 300 cycles
	localparam data_t fill_key       = 64'h5a5a_0000_0000_0000;

	logic         clock;
	logic         reset;
	logic         inst_valid;
	lsq_op_e      inst_op;
	data_t        inst_opa;
	data_t        inst_opb;
	logic         inst_opb_valid;
	data_t        inst_rega;
	logic         inst_rega_valid;
	rob_idx_t     inst_rob_idx;
	prf_tag_t     inst_dest_tag;
	logic         cdb_in_valid;
	prf_tag_t     cdb_in_tag;
	data_t        cdb_in_data;
	rob_idx_t     rob_head;
	logic         mispredict;
	mem_tag_t     mem_response;
	mem_tag_t     mem_tag;
	data_t        mem_data_in;
	bus_command_e mem_command;
	addr_t        mem_address;
	data_t        mem_data_out;
	logic         cdb_valid;
	prf_tag_t     cdb_tag;
	rob_idx_t     cdb_rob_idx;
	data_t        cdb_data;
	logic         lsq_full;
	logic         refuse_enable;

	int       errors = 0;
	int       checks = 0;
	int       cycles = 0;
	int       got_count [32];    // Results seen per ROB index
	prf_tag_t got_tag [32];
	data_t    got_data [32];

	lsq_clock_gen u_clock_gen (.clock, .reset);

	dcache_model u_dcache (.clock, .reset, .refuse_enable, .mem_command, .mem_address,
		.mem_data_out, .mem_response, .mem_tag, .mem_data_in);

	lsq_top #(.lq_size(8), .sq_size(8)) u_dut (.*);

	////////////////////////////////////////
	// Monitor and timeout
	////////////////////////////////////////

	always @(negedge clock) begin    // CDB is stable mid-cycle
		if (!reset && cdb_valid) begin
			got_count[cdb_rob_idx]++;
			got_tag[cdb_rob_idx]  = cdb_tag;
			got_data[cdb_rob_idx] = cdb_data;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, a test never finished", cycles);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Memory word at an address that was never stored to
	function automatic data_t fill_word(input addr_t a);
		return a ^ fill_key;
	endfunction

	task automatic check_value(input string test, input string what, input data_t exp,
			input data_t act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("mismatch %s %s expected %h actual %h", test, what, exp, act);
		end
	endtask

	task automatic check_true(input string test, input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s %s", test, msg);
		end
	endtask

	task automatic clear_results();
		for (int i = 0; i < 32; i++) got_count[i] = 0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clock);
	endtask

	// One-cycle dispatch strobe, one idle cycle after it
	task automatic dispatch(input lsq_op_e op, input int rob, input int dest, input data_t opa,
			input data_t opb, input logic opb_ok, input data_t data);
		@(posedge clock);
		inst_valid      <= 1'b1;
		inst_op         <= op;
		inst_opa        <= opa;
		inst_opb        <= opb;
		inst_opb_valid  <= opb_ok;
		inst_rega       <= data;
		inst_rega_valid <= 1'b1;
		inst_rob_idx    <= rob_idx_t'(rob);
		inst_dest_tag   <= prf_tag_t'(dest);
		@(posedge clock);
		inst_valid <= 1'b0;
	endtask

	task automatic wait_result(input string test, input int rob);
		int n = 0;
		while (got_count[rob] == 0 && n < 100) begin
			@(posedge clock);
			n++;
		end
		check_true(test, got_count[rob] != 0, $sformatf("got no CDB result for ROB %0d", rob));
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_after_reset();
		check_value("after_reset", "cdb_valid", '0, data_t'(cdb_valid));
		check_value("after_reset", "lsq_full", '0, data_t'(lsq_full));
		check_value("after_reset", "mem_command", data_t'(bus_none), data_t'(mem_command));
	endtask

	task automatic test_ready_load();
		clear_results();
		dispatch(op_load, 1, 10, 64'h1000, 64'h28, 1'b1, '0);
		wait_result("ready_load", 1);
		idle(5);
		check_value("ready_load", "count", 1, data_t'(got_count[1]));
		check_value("ready_load", "tag", 10, data_t'(got_tag[1]));
		check_value("ready_load", "data", fill_word(64'h1028), got_data[1]);
	endtask

	task automatic test_waiting_load();
		clear_results();
		dispatch(op_load, 2, 11, 64'h2000, 64'd20, 1'b0, '0);    // Offset waits on tag 20
		idle(8);
		check_value("waiting_load", "early count", 0, data_t'(got_count[2]));
		@(posedge clock);
		cdb_in_valid <= 1'b1;
		cdb_in_tag   <= 6'd20;
		cdb_in_data  <= 64'h40;
		@(posedge clock);
		cdb_in_valid <= 1'b0;
		wait_result("waiting_load", 2);
		idle(5);
		check_value("waiting_load", "count", 1, data_t'(got_count[2]));
		check_value("waiting_load", "tag", 11, data_t'(got_tag[2]));
		check_value("waiting_load", "data", fill_word(64'h2040), got_data[2]);
	endtask

	task automatic test_store_then_load();
		clear_results();
		dispatch(op_store, 4, 0, 64'h3000, 64'h10, 1'b1, 64'hdead_beef_0123_4567);
		dispatch(op_load, 5, 12, 64'h3000, 64'h10, 1'b1, '0);
		idle(8);
		check_value("store_load", "early store count", 0, data_t'(got_count[4]));
		check_value("store_load", "early load count", 0, data_t'(got_count[5]));
		@(posedge clock);
		rob_head <= 5'd4;    // Store reaches the ROB head
		wait_result("store_load", 4);
		wait_result("store_load", 5);
		idle(5);
		check_value("store_load", "store count", 1, data_t'(got_count[4]));
		check_value("store_load", "store tag", 0, data_t'(got_tag[4]));
		check_value("store_load", "store data", '0, got_data[4]);
		check_value("store_load", "load count", 1, data_t'(got_count[5]));
		check_value("store_load", "load tag", 12, data_t'(got_tag[5]));
		check_value("store_load", "load data", 64'hdead_beef_0123_4567, got_data[5]);
	endtask

	task automatic test_refusals();
		clear_results();
		@(posedge clock);
		refuse_enable <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			dispatch(op_load, 8 + i, 16 + i, 64'h4000 + data_t'(i) * 64'h100, data_t'(i) * 8,
				1'b1, '0);
		end
		for (int i = 0; i < 8; i++) wait_result("refusals", 8 + i);
		idle(10);
		for (int i = 0; i < 8; i++) begin
			check_value("refusals", "count", 1, data_t'(got_count[8 + i]));
			check_value("refusals", "data",
				fill_word(64'h4000 + data_t'(i) * 64'h100 + data_t'(i) * 8), got_data[8 + i]);
		end
		@(posedge clock);
		refuse_enable <= 1'b0;
	endtask

	task automatic test_fill_squash();
		int sent = 0;
		int n = 0;
		clear_results();
		while (!lsq_full && sent < 12) begin    // Offsets wait on tag 40
			dispatch(op_load, 16 + sent, 32 + sent, 64'h6000, 64'd40, 1'b0, '0);
			sent++;
		end
		check_true("fill_squash", lsq_full, "lsq_full never rose while filling the load queue");
		@(posedge clock);
		cdb_in_valid <= 1'b1;    // Wake all entries so the lowest slot issues before the squash
		cdb_in_tag   <= 6'd40;
		cdb_in_data  <= 64'h8;
		@(posedge clock);
		cdb_in_valid <= 1'b0;
		@(posedge clock);
		mispredict <= 1'b1;
		@(posedge clock);
		mispredict <= 1'b0;
		while (lsq_full && n < 10) begin
			@(posedge clock);
			n++;
		end
		check_true("fill_squash", !lsq_full, "lsq_full stayed high after the mispredict");
		idle(10);
		for (int i = 0; i < sent; i++) begin
			check_value("fill_squash", "squashed count", 0, data_t'(got_count[16 + i]));
		end
		dispatch(op_load, 30, 45, 64'h5000, 64'h18, 1'b1, '0);
		wait_result("fill_squash", 30);
		idle(5);
		check_value("fill_squash", "count", 1, data_t'(got_count[30]));
		check_value("fill_squash", "tag", 45, data_t'(got_tag[30]));
		check_value("fill_squash", "data", fill_word(64'h5018), got_data[30]);
	endtask

	initial begin
		inst_valid      = 1'b0;
		inst_op         = op_none;
		inst_opa        = '0;
		inst_opb        = '0;
		inst_opb_valid  = 1'b0;
		inst_rega       = '0;
		inst_rega_valid = 1'b0;
		inst_rob_idx    = '0;
		inst_dest_tag   = '0;
		cdb_in_valid    = 1'b0;
		cdb_in_tag      = '0;
		cdb_in_data     = '0;
		rob_head        = '0;
		mispredict      = 1'b0;
		refuse_enable   = 1'b0;
		@(negedge reset);
		@(posedge clock);
		test_after_reset();
		test_ready_load();
		test_waiting_load();
		test_store_then_load();
		test_refusals();
		test_fill_squash();
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- list.f
hdl/lsq_core_pkg.sv
hdl/lsq_bus_pkg.sv
hdl/lsq_dispatch.sv
hdl/load_queue.sv
hdl/store_queue.sv
hdl/dcache_arbiter.sv
hdl/result_arbiter.sv
hdl/lsq_top.sv
test/lsq_clock_gen.sv
test/dcache_model.sv
test/lsq_tb.sv

//--- Makefile
# Verilator build, run and lint for the load/store queue

VERILATOR   ?= verilator
FILELIST    ?= list.f
TB_TOP      ?= lsq_tb
RTL_TOP     ?= lsq_top
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS  ?= -Wall
PASS_TEXT   ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
